/* vlog.f */
common/pa_types_pkg.sv
common/pa_bus_pkg.sv
common/pa_data_if.sv
source/bus_w.sv
source/bus_a.sv
source/alu.sv
source/at_reg.sv
source/pa_regs.sv
source/pa.sv
test/pa_chk.sv
test/pa_tb.sv

/* run.sh */
#!/bin/sh
# build the pa testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f vlog.f --top-module pa_tb -o pa_sim \
	&& ./obj_dir/pa_sim | grep "All tests passed!" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* test/pa_tb.sv */
/*
	Random testbench for the P-A arithmetic and address unit.
	Drives seeded random controls and data on the falling edge, keeps a
	cycle model of AC, AR, IC, AT and wzi, and checks every output.
*/

module pa_tb;

	localparam int n_cycles = 2000;
	localparam int rst_cycles = 8;
	localparam int cycle_limit = 4 * n_cycles + rst_cycles;

	logic __clk = 1'b0;
	logic rst_n;
	pa_bus_pkg::w_src_t w_sel;
	pa_bus_pkg::a_src_t a_sel;
	pa_bus_pkg::dad_src_t dsel;
	pa_types_pkg::alu_op_t op;
	pa_types_pkg::word_t ir, kl, rdt, ki, l;
	logic w_dt, as2, strob1, strob2, w_ac, w_ar, w_ic, arp1, arm4, icp1, off, barnb;
	logic at_load, at_shift, eat0;
	pa_types_pkg::word_t w, ddt, dad;
	logic carry, s0, wzi, at15, arz, zga;

	// model copies of the registers
	pa_types_pkg::word_t m_ac, m_ar, m_ic, m_at;
	logic m_wzi;
	int cycles = 0;

	pa pa_inst (.*);

	always #4 __clk = ~__clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input pa_types_pkg::word_t exp,
			input pa_types_pkg::word_t act);
		if (act !== exp)
			report_failure($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_op_result(input string name, input pa_types_pkg::alu_op_t op_v,
			input pa_types_pkg::word_t exp, input pa_types_pkg::word_t act);
		if (act !== exp)
			report_failure($sformatf("[FAIL] %s %s: expected %h, actual %h",
				name, op_v.name(), exp, act));
	endtask

	// timeout guard
	always @(posedge __clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
			report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
	end

	function automatic logic one_in_three();
		return $urandom_range(0, 2) == 0;
	endfunction

	task automatic drive_random();
		w_sel = pa_bus_pkg::w_src_t'(3'($urandom_range(0, 7)));
		a_sel = pa_bus_pkg::a_src_t'(3'($urandom_range(0, 4)));
		dsel = pa_bus_pkg::dad_src_t'(2'($urandom_range(0, 3)));
		op = pa_types_pkg::alu_op_t'(3'($urandom_range(0, 6)));
		ir = pa_types_pkg::word_t'($urandom());
		kl = pa_types_pkg::word_t'($urandom());
		rdt = pa_types_pkg::word_t'($urandom());
		ki = pa_types_pkg::word_t'($urandom());
		l = pa_types_pkg::word_t'($urandom());
		as2 = 1'($urandom_range(0, 1));
		barnb = 1'($urandom_range(0, 1));
		eat0 = 1'($urandom_range(0, 1));
		w_dt = one_in_three();
		strob1 = one_in_three();
		strob2 = one_in_three();
		w_ac = one_in_three();
		w_ar = one_in_three();
		w_ic = one_in_three();
		arp1 = one_in_three();
		arm4 = one_in_three();
		icp1 = one_in_three();
		at_load = one_in_three();
		at_shift = one_in_three();
		// rarer, so IC gets to count
		off = ($urandom_range(0, 7) == 0);
	endtask

	// short operand: sign-extended low byte of ir
	function automatic pa_types_pkg::word_t model_a();
		case (a_sel)
			pa_bus_pkg::as_ir: return {{8{ir[8]}}, ir[8:15]};
			pa_bus_pkg::as_l: return l;
			pa_bus_pkg::as_ar: return m_ar;
			pa_bus_pkg::as_ic: return m_ic;
			default: return '0;
		endcase
	endfunction

	// carry in bit 16, result word below it
	function automatic logic [16:0] model_alu(input pa_types_pkg::word_t a);
		logic [16:0] r;
		case (op)
			pa_types_pkg::op_add: r = {1'b0, a} + {1'b0, m_ac};
			pa_types_pkg::op_sub: begin
				r = {1'b0, m_ac} - {1'b0, a};
				// borrow lands in bit 16, carry is its inverse
				r[16] = ~r[16];
			end
			pa_types_pkg::op_and: r = {1'b0, a & m_ac};
			pa_types_pkg::op_or: r = {1'b0, a | m_ac};
			pa_types_pkg::op_xor: r = {1'b0, a ^ m_ac};
			pa_types_pkg::op_pass_a: r = {1'b0, a};
			pa_types_pkg::op_inc_a: r = {1'b0, a} + 17'd1;
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic pa_types_pkg::word_t model_w(input pa_types_pkg::word_t a);
		case (w_sel)
			pa_bus_pkg::ws_ir: return ir;
			pa_bus_pkg::ws_kl: return kl;
			pa_bus_pkg::ws_rdt: return rdt;
			pa_bus_pkg::ws_ki: return ki;
			pa_bus_pkg::ws_at: return m_at;
			pa_bus_pkg::ws_ac: return m_ac;
			pa_bus_pkg::ws_a: return a;
			default: return '0;
		endcase
	endfunction

	function automatic pa_types_pkg::word_t model_dad();
		case (dsel)
			pa_bus_pkg::ds_ic: return m_ic;
			pa_bus_pkg::ds_ar: return m_ar;
			default: return '0;
		endcase
	endfunction

	initial begin
		pa_types_pkg::word_t ea, ef, ew, ed;
		logic ec;
		logic load_ok;
		logic [16:0] res;

		void'($urandom(32'hc33f));
		rst_n = 1'b0;
		{w_dt, as2, strob1, strob2, w_ac, w_ar, w_ic, arp1, arm4, icp1, off, barnb} = '0;
		{at_load, at_shift, eat0} = '0;
		{ir, kl, rdt, ki, l} = '0;
		w_sel = pa_bus_pkg::ws_zero;
		a_sel = pa_bus_pkg::as_zero;
		dsel = pa_bus_pkg::ds_none;
		op = pa_types_pkg::op_add;
		{m_ac, m_ar, m_ic, m_at} = '0;
		m_wzi = 1'b0;
		repeat (rst_cycles) @(negedge __clk);
		rst_n = 1'b1;

		repeat (n_cycles) begin
			@(negedge __clk);
			drive_random();
			ed = model_dad();
			// force a key match now and then
			if ($urandom_range(0, 3) == 0)
				kl = {~barnb, ed[1:15]};
			#2;
			ea = model_a();
			res = model_alu(ea);
			ef = res[15:0];
			ec = res[16];
			ew = model_w(ea);

			check_word("w bus", ew, w);
			check_word("ddt", w_dt ? ew : pa_types_pkg::word_t'(0), ddt);
			check_op_result("alu f", op, ef, pa_inst.data.f);
			check_bit("carry", ec, carry);
			check_bit("s0", ef[0], s0);
			check_word("dad", ed, dad);
			check_bit("zga", kl == {~barnb, ed[1:15]}, zga);
			check_bit("arz", m_ar == '0, arz);
			check_bit("wzi", m_wzi, wzi);
			check_bit("at15", m_at[15], at15);

			// register effects at the coming rising edge
			load_ok = (strob1 && !as2) || (strob2 && as2);
			if (w_ac && load_ok)
				m_ac = ew;
			if (w_ar && load_ok)
				m_ar = ew;
			else if (arp1 && strob1 && !as2)
				m_ar = m_ar + 16'd1;
			else if (arm4 && strob1 && !as2)
				m_ar = m_ar - 16'd4;
			if (off)
				m_ic = '0;
			else if (w_ic && load_ok)
				m_ic = ew;
			else if (icp1 && strob1)
				m_ic = m_ic + 16'd1;
			if (at_load)
				m_at = ef;
			else if (at_shift)
				m_at = {eat0, m_at[0:14]};
			if (as2 && strob1)
				m_wzi = (ef == '0);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

/* test/pa_chk.sv */
/*
	Concurrent assertions on the P-A registers and the zero flag.
	Bound into pa_regs for AR and IC, and into alu for wzi.
*/

module pa_chk #(
	parameter bit regs_side = 1'b1
) (
	input logic __clk,
	input logic rst_n,
	input logic as2,
	input logic strob1,
	input logic strob2,
	input logic w_ar,
	input logic off,
	input logic arz,
	input logic wzi,
	input pa_types_pkg::word_t w,
	input pa_types_pkg::word_t ar,
	input pa_types_pkg::word_t ic
);

	if (regs_side) begin : regs_checks
		off_clears_ic: assert property (@(posedge __clk) disable iff (!rst_n)
			off |=> (ic == '0))
			else $error("off did not clear IC");

		// qualified load in either strobe phase
		ar_load: assert property (@(posedge __clk) disable iff (!rst_n)
			(w_ar && ((strob1 && !as2) || (strob2 && as2))) |=> (ar == $past(w)))
			else $error("AR did not take the W bus");

		// zero flag follows the word just loaded into AR
		arz_tracks_ar: assert property (@(posedge __clk) disable iff (!rst_n)
			(w_ar && ((strob1 && !as2) || (strob2 && as2)))
				|=> (arz == ($past(w) == '0)))
			else $error("arz does not match the word loaded into AR");
	end else begin : alu_checks
		wzi_in_reset: assert property (@(posedge __clk) !rst_n |-> !wzi)
			else $error("wzi set during reset");
	end

endmodule

bind pa_regs pa_chk #(.regs_side(1'b1)) regs_chk_i (
	.__clk(__clk), .rst_n(rst_n), .as2(as2), .strob1(strob1), .strob2(strob2),
	.w_ar(w_ar), .off(off), .arz(arz), .wzi(1'b0),
	.w(data.w), .ar(data.ar), .ic(data.ic)
);

bind alu pa_chk #(.regs_side(1'b0)) alu_chk_i (
	.__clk(__clk), .rst_n(rst_n), .as2(as2), .strob1(strob1), .strob2(1'b0),
	.w_ar(1'b0), .off(1'b0), .arz(1'b0), .wzi(wzi),
	.w('0), .ar('0), .ic('0)
);

/* source/pa.sv */
/*
	Top level of the P-A arithmetic and address unit.
	Connects the bus multiplexers, the ALU and the registers through
	the internal datapath interface.
*/

module pa #(
	parameter int word_w = pa_types_pkg::word_w
) (
	input logic __clk,
	input logic rst_n,
	input pa_bus_pkg::w_src_t w_sel,
	input pa_bus_pkg::a_src_t a_sel,
	input pa_bus_pkg::dad_src_t dsel,
	input pa_types_pkg::alu_op_t op,
	input logic [0:word_w-1] ir,
	input logic [0:word_w-1] kl,
	input logic [0:word_w-1] rdt,
	input logic [0:word_w-1] ki,
	input logic [0:word_w-1] l,
	input logic w_dt,
	input logic as2,
	input logic strob1,
	input logic strob2,
	input logic w_ac,
	input logic w_ar,
	input logic w_ic,
	input logic arp1,
	input logic arm4,
	input logic icp1,
	input logic off,
	input logic barnb,
	input logic at_load,
	input logic at_shift,
	input logic eat0,
	output logic [0:word_w-1] w,
	output logic [0:word_w-1] ddt,
	output logic [0:word_w-1] dad,
	output logic carry,
	output logic s0,
	output logic wzi,
	output logic at15,
	output logic arz,
	output logic zga
);

	pa_data_if data();

	bus_w #(.word_w(word_w)) bus_w_i (
		.sel(w_sel), .ir(ir), .kl(kl), .rdt(rdt), .ki(ki),
		.w_dt(w_dt), .ddt(ddt), .data(data)
	);

	bus_a #(.word_w(word_w)) bus_a_i (
		.sel(a_sel), .ir(ir), .l(l), .data(data)
	);

	alu #(.word_w(word_w)) alu_i (
		.__clk(__clk), .rst_n(rst_n), .op(op), .as2(as2), .strob1(strob1),
		.carry(carry), .s0(s0), .wzi(wzi), .data(data)
	);

	at_reg #(.word_w(word_w)) at_i (
		.__clk(__clk), .rst_n(rst_n), .at_load(at_load), .at_shift(at_shift),
		.eat0(eat0), .at15(at15), .data(data)
	);

	pa_regs #(.word_w(word_w)) regs_i (
		.__clk(__clk), .rst_n(rst_n), .as2(as2), .strob1(strob1), .strob2(strob2),
		.w_ac(w_ac), .w_ar(w_ar), .w_ic(w_ic), .arp1(arp1), .arm4(arm4),
		.icp1(icp1), .off(off), .barnb(barnb), .dsel(dsel), .kl(kl),
		.dad(dad), .arz(arz), .zga(zga), .data(data)
	);

	assign w = data.w;

endmodule

/* source/pa_regs.sv */
/*
	AC, AR and IC registers of the P-A unit with their strobe gating.
	Also forms arz, the memory address dad and the key compare zga.
	Loads are taken in phase A (strob1, as2 low) or phase B (strob2, as2 high).
*/

module pa_regs #(
	parameter int word_w = pa_types_pkg::word_w
) (
	input logic __clk,
	input logic rst_n,
	input logic as2,
	input logic strob1,
	input logic strob2,
	input logic w_ac,
	input logic w_ar,
	input logic w_ic,
	input logic arp1,
	input logic arm4,
	input logic icp1,
	input logic off,
	input logic barnb,
	input pa_bus_pkg::dad_src_t dsel,
	input pa_types_pkg::word_t kl,
	output pa_types_pkg::word_t dad,
	output logic arz,
	output logic zga,
	pa_data_if.regs data
);

	logic phase_a;
	logic phase_b;
	logic load_ok;

	assign phase_a = strob1 & ~as2;
	assign phase_b = strob2 & as2;
	assign load_ok = phase_a | phase_b;

	// accumulator
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			data.ac <= '0;
		end else if (w_ac && load_ok) begin
			data.ac <= data.w;
		end
	end

	// address register, load then +1 then -4
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			data.ar <= '0;
		end else if (w_ar && load_ok) begin
			data.ar <= data.w;
		end else if (arp1 && phase_a) begin
			data.ar <= data.ar + word_w'(1);
		end else if (arm4 && phase_a) begin
			data.ar <= data.ar - word_w'(4);
		end
	end

	// instruction counter, off overrides everything
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			data.ic <= '0;
		end else if (off) begin
			data.ic <= '0;
		end else if (w_ic && load_ok) begin
			data.ic <= data.w;
		end else if (icp1 && strob1) begin
			data.ic <= data.ic + word_w'(1);
		end
	end

	assign arz = (data.ar == '0);

	always_comb begin
		case (dsel)
			pa_bus_pkg::ds_ic: dad = data.ic;
			pa_bus_pkg::ds_ar: dad = data.ar;
			default: dad = '0;
		endcase
	end

	// key compare, bit 0 taken from the inverted barnb
	assign zga = (kl == {~barnb, dad[1:word_w-1]});

endmodule

/* source/at_reg.sv */
/*
	AT register of the P-A unit.
	Loads the ALU result or shifts right by one with eat0 entering bit 0.
*/

module at_reg #(
	parameter int word_w = pa_types_pkg::word_w
) (
	input logic __clk,
	input logic rst_n,
	input logic at_load,
	input logic at_shift,
	input logic eat0,
	output logic at15,
	pa_data_if.at_reg data
);

	// load wins over shift
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			data.at <= '0;
		end else if (at_load) begin
			data.at <= data.f;
		end else if (at_shift) begin
			data.at <= {eat0, data.at[0:word_w-2]};
		end
	end

	// next bit to leave on a shift
	assign at15 = data.at[word_w-1];

endmodule

/* source/alu.sv */
/*
	16-bit ALU of the P-A unit, with carry out and zero detection.
	f is combinational from a and ac; wzi keeps the zero result,
	sampled when as2 and strob1 are both high.
*/

module alu #(
	parameter int word_w = pa_types_pkg::word_w
) (
	input logic __clk,
	input logic rst_n,
	input pa_types_pkg::alu_op_t op,
	input logic as2,
	input logic strob1,
	output logic carry,
	output logic s0,
	output logic wzi,
	pa_data_if.alu data
);

	localparam logic [0:word_w] one = 1;

	// bit 0 holds the carry out
	logic [0:word_w] sum;
	logic zsum;

	always_comb begin
		case (op)
			pa_types_pkg::op_add:
				sum = {1'b0, data.a} + {1'b0, data.ac};
			// two's complement, carry out means no borrow
			pa_types_pkg::op_sub:
				sum = {1'b0, data.ac} + {1'b0, ~data.a} + one;
			pa_types_pkg::op_and:
				sum = {1'b0, data.a & data.ac};
			pa_types_pkg::op_or:
				sum = {1'b0, data.a | data.ac};
			pa_types_pkg::op_xor:
				sum = {1'b0, data.a ^ data.ac};
			pa_types_pkg::op_pass_a:
				sum = {1'b0, data.a};
			pa_types_pkg::op_inc_a:
				sum = {1'b0, data.a} + one;
			default:
				sum = '0;
		endcase
	end

	assign data.f = sum[1:word_w];
	assign carry = sum[0];
	assign s0 = data.f[0];
	assign zsum = (data.f == '0);

	// adder zero flag
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			wzi <= 1'b0;
		end else if (as2 && strob1) begin
			wzi <= zsum;
		end
	end

endmodule

/* source/bus_a.sv */
/*
	A bus multiplexer of the P-A unit.
	Routes a register or an input word to the ALU's A operand.
*/

module bus_a #(
	parameter int word_w = pa_types_pkg::word_w
) (
	input pa_bus_pkg::a_src_t sel,
	input pa_types_pkg::word_t ir,
	input pa_types_pkg::word_t l,
	pa_data_if.bus_a data
);

	// short operand is the low byte of ir
	logic sign;

	assign sign = ir[word_w-8];

	always_comb begin
		case (sel)
			pa_bus_pkg::as_ir: data.a = {{(word_w-8){sign}}, ir[word_w-8:word_w-1]};
			pa_bus_pkg::as_l: data.a = l;
			pa_bus_pkg::as_ar: data.a = data.ar;
			pa_bus_pkg::as_ic: data.a = data.ic;
			default: data.a = '0;
		endcase
	end

endmodule

/* source/bus_w.sv */
/*
	W bus multiplexer of the P-A unit.
	Picks the source for all register loads and gates it onto ddt.
*/

module bus_w #(
	parameter int word_w = pa_types_pkg::word_w
) (
	input pa_bus_pkg::w_src_t sel,
	input pa_types_pkg::word_t ir,
	input pa_types_pkg::word_t kl,
	input pa_types_pkg::word_t rdt,
	input pa_types_pkg::word_t ki,
	input logic w_dt,
	output pa_types_pkg::word_t ddt,
	pa_data_if.bus_w data
);

	always_comb begin
		case (sel)
			pa_bus_pkg::ws_ir: data.w = ir;
			pa_bus_pkg::ws_kl: data.w = kl;
			pa_bus_pkg::ws_rdt: data.w = rdt;
			pa_bus_pkg::ws_ki: data.w = ki;
			pa_bus_pkg::ws_at: data.w = data.at;
			pa_bus_pkg::ws_ac: data.w = data.ac;
			pa_bus_pkg::ws_a: data.w = data.a;
			default: data.w = '0;
		endcase
	end

	// data output driven only while w_dt is up
	assign ddt = data.w & {word_w{w_dt}};

endmodule

/* common/pa_data_if.sv */
/*
	Internal datapath words of the P-A unit.
	Each block connects through its own modport and drives one group of words.
*/

interface pa_data_if;

	pa_types_pkg::word_t w;
	pa_types_pkg::word_t a;
	pa_types_pkg::word_t f;
	pa_types_pkg::word_t at;
	pa_types_pkg::word_t ac;
	pa_types_pkg::word_t ar;
	pa_types_pkg::word_t ic;

	modport bus_w (output w, input at, ac, a);

	modport bus_a (output a, input ar, ic);

	modport alu (output f, input a, ac);

	modport at_reg (output at, input f);

	modport regs (output ac, ar, ic, input w);

endinterface

/* common/pa_bus_pkg.sv */
/*
	Select encodings for the W bus, the A bus and the address output.
*/

package pa_bus_pkg;

	// W bus source, feeds every register load
	typedef enum logic [2:0] {
		ws_zero = 3'd0,
		ws_ir   = 3'd1,
		ws_kl   = 3'd2,
		ws_rdt  = 3'd3,
		ws_ki   = 3'd4,
		ws_at   = 3'd5,
		ws_ac   = 3'd6,
		ws_a    = 3'd7
	} w_src_t;

	// A bus source, feeds the ALU
	typedef enum logic [2:0] {
		as_zero = 3'd0,
		as_ir   = 3'd1,
		as_l    = 3'd2,
		as_ar   = 3'd3,
		as_ic   = 3'd4
	} a_src_t;

	// memory address output, both-sources code gives zero
	typedef enum logic [1:0] {
		ds_none  = 2'd0,
		ds_ic    = 2'd1,
		ds_ar    = 2'd2,
		ds_none2 = 2'd3
	} dad_src_t;

endpackage

/* common/pa_types_pkg.sv */
/*
	Datapath types for the P-A arithmetic and address unit.
	Defines the word width, the MSB-first word type and the ALU opcodes.
	Blocks and the testbench refer to these by scoped name.
*/

package pa_types_pkg;

	// data word width, bit 0 is the most significant
	localparam int word_w = 16;

	typedef logic [0:word_w-1] word_t;

	// ALU function select
	typedef enum logic [2:0] {
		op_add    = 3'd0,
		// ac minus a, carry set when no borrow
		op_sub    = 3'd1,
		op_and    = 3'd2,
		op_or     = 3'd3,
		op_xor    = 3'd4,
		op_pass_a = 3'd5,
		op_inc_a  = 3'd6
	} alu_op_t;

endpackage
